//--- tb.f
+incdir+sim
hw/led_panel_pkg.sv
hw/scan_timer.sv
hw/led_frame_builder.sv
hw/scan_fsm.sv
hw/column_shifter.sv
hw/led_panel_top.sv
sim/led_panel_tb.sv

//--- Bender.yml
package:
  name: led_panel

sources:
  - hw/led_panel_pkg.sv
  - hw/scan_timer.sv
  - hw/led_frame_builder.sv
  - hw/scan_fsm.sv
  - hw/column_shifter.sv
  - hw/led_panel_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/led_panel_tb.sv

//--- sim/led_panel_checks.svh
//--------------------------------------------------------------------------
// LED panel testbench helpers
// galois LFSR for random stimulus and the typed compare tasks
//--------------------------------------------------------------------------

`ifndef LED_PANEL_CHECKS_SVH
`define LED_PANEL_CHECKS_SVH

// 16 bit galois LFSR, polynomial x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
   end
   return s >> 1;
endfunction

// one LFSR step per bit, lsb filled first
task automatic take_bits(input int n, output logic [15:0] v);
   v = '0;
   for (int i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
   end
endtask

// serialized column word against the reference frame
task automatic check_column(input int col, input motor_vec_t got, input motor_vec_t want);
   if (got !== want) begin
      val_err++;
      $display("ERROR data_o column %0d: got 0x%h, expected 0x%h", col, got, want);
   end
endtask

task automatic check_csel(input column_idx_t got, input column_idx_t want);
   if (got !== want) begin
      val_err++;
      $display("ERROR csel_o: got 0x%h, expected 0x%h", got, want);
   end
endtask

// single bit panel outputs, named by the caller
task automatic check_blink(input string sig, input logic got, input logic want);
   if (got !== want) begin
      val_err++;
      $display("ERROR %s at %0t: got 0x%h, expected 0x%h", sig, $time, got, want);
   end
endtask

`endif

//--- sim/led_panel_tb.sv
//--------------------------------------------------------------------------
// LED status panel testbench
// grabs the serial matrix stream back into a frame and compares it with
// a reference model of the switch mapping; also checks scan order,
// fail debouncing and the heartbeat pattern
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module led_panel_tb;

   import led_panel_pkg::*;

   localparam int CLK_PERIOD     = 100;
   localparam int RESET_CYCLES   = 8;
   localparam int FRAME_CYCLES   = NUM_COLUMNS * 35 * SCAN_DIVIDER;
   localparam int TIMEOUT_CYCLES = 30 * FRAME_CYCLES + 200;
   localparam int FAIL_PULSE     = FAIL_DEBOUNCE_CYCLES / 2;
   localparam int BLINK_SLOT     = BLINK_ON_CYCLES + BLINK_OFF_CYCLES;
   localparam int BLINK_PERIOD   = BLINK_PULSES * BLINK_SLOT + BLINK_SLOT;

   logic        display;
   logic        rst_n_i;
   logic        cfg_we_i;
   motor_idx_t  cfg_motor_i;
   motor_cfg_t  cfg_data_i;
   motor_vec_t  sw_a_raw_i;
   motor_vec_t  sw_b_raw_i;
   motor_vec_t  overheat_i;
   motor_vec_t  fail_i;
   logic        blank_o;
   logic        sclk_o;
   logic        data_o;
   logic        latch_o;
   column_idx_t csel_o;
   logic        blink_o;

   // reference state and grabbed frame
   motor_cfg_t  cfg_model [NUM_MOTORS];
   motor_vec_t  fail_model = '0;
   motor_vec_t  grabbed [NUM_COLUMNS];
   column_idx_t csel_want  = '0;
   logic [15:0] lfsr_q     = 16'd90;
   int          latch_cnt  = 0;
   int          sclk_edges = 0;
   int          cycle_cnt  = 0;
   int          val_err    = 0;
   int          other_err  = 0;

   `include "led_panel_checks.svh"

   led_panel_top u_dut (
      .display     (display),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_motor_i (cfg_motor_i),
      .cfg_data_i  (cfg_data_i),
      .sw_a_raw_i  (sw_a_raw_i),
      .sw_b_raw_i  (sw_b_raw_i),
      .overheat_i  (overheat_i),
      .fail_i      (fail_i),
      .blank_o     (blank_o),
      .sclk_o      (sclk_o),
      .data_o      (data_o),
      .latch_o     (latch_o),
      .csel_o      (csel_o),
      .blink_o     (blink_o)
   );

   initial begin
      display = 1'b0;
      forever #(CLK_PERIOD / 2) display = ~display;
   end

   // run limit, sized from the total frame count of all tests
   always @(posedge display) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles, the tests did not finish", cycle_cnt);
         $display("errors: %0d value mismatches, %0d other failures", val_err, other_err + 1);
         $display("test failed");
         $finish;
      end
   end

   always @(posedge sclk_o) begin
      sclk_edges++;
   end

   //-----------------------------------------------------------------------
   // frame grabber
   //-----------------------------------------------------------------------

   // one column per blank..latch window, bit 15 arrives first
   initial begin : frame_grabber
      motor_vec_t word;
      wait (rst_n_i === 1'b1);
      forever begin
         @(posedge blank_o);
         word = '0;
         repeat (NUM_MOTORS) begin
            @(posedge sclk_o);
            word = {word[NUM_MOTORS-2:0], data_o};
         end
         @(posedge latch_o);
         if (sclk_edges != NUM_MOTORS) begin
            other_err++;
            $display("column %0d was latched after %0d sclk_o rising edges instead of %0d",
                     csel_o, sclk_edges, NUM_MOTORS);
         end
         sclk_edges = 0;
         check_csel(csel_o, csel_want);
         grabbed[csel_o] = word;
         // columns visited 0..5 in order
         csel_want = (csel_want == column_idx_t'(NUM_COLUMNS - 1)) ? '0 : csel_want + 1'b1;
         latch_cnt++;
      end
   end

   //-----------------------------------------------------------------------
   // reference model
   //-----------------------------------------------------------------------

   function automatic motor_vec_t model_column(input int col);
      motor_vec_t  v;
      switch_cfg_t sc;
      logic        on;
      logic        green_col;
      if (col == COL_OVERHEAT) begin
         return overheat_i;
      end
      if (col == COL_FAIL) begin
         return fail_model;
      end
      v         = '0;
      green_col = (col == COL_A_GREEN) || (col == COL_B_GREEN);
      for (int m = 0; m < NUM_MOTORS; m++) begin
         if (col <= COL_A_RED) begin
            sc = cfg_model[m].sw_a;
            on = !sw_a_raw_i[m];
         end else begin
            sc = cfg_model[m].sw_b;
            on = !sw_b_raw_i[m];
         end
         // invert swaps the actuated level
         if (sc.invert) begin
            on = !on;
         end
         v[m] = on && ((sc.color == LED_BOTH) ||
                       (sc.color == (green_col ? LED_GREEN : LED_RED)));
      end
      return v;
   endfunction

   // n full frames of latches from now
   task automatic wait_frames(input int n);
      int target;
      target = latch_cnt + n * NUM_COLUMNS;
      wait (latch_cnt >= target);
   endtask

   task automatic check_frame();
      for (int c = 0; c < NUM_COLUMNS; c++) begin
         check_column(c, grabbed[c], model_column(c));
      end
   endtask

   task automatic write_cfg(input motor_idx_t m, input motor_cfg_t d);
      @(posedge display);
      cfg_we_i    <= 1'b1;
      cfg_motor_i <= m;
      cfg_data_i  <= d;
      @(posedge display);
      cfg_we_i    <= 1'b0;
      cfg_model[m] = d;
   endtask

   //-----------------------------------------------------------------------
   // directed tests
   //-----------------------------------------------------------------------

   task automatic test_reset_and_order();
      rst_n_i <= 1'b0;
      repeat (RESET_CYCLES) @(posedge display);
      check_blink("blank_o", blank_o, 1'b0);
      check_blink("sclk_o", sclk_o, 1'b0);
      check_blink("latch_o", latch_o, 1'b0);
      check_blink("blink_o", blink_o, 1'b0);
      check_csel(csel_o, '0);
      rst_n_i <= 1'b1;
      // order and edge counts are checked by the grabber on every latch
      wait_frames(2);
   endtask

   task automatic test_default_mapping();
      // all raw inputs idle high, panel dark
      check_frame();
      @(posedge display);
      sw_a_raw_i[0]              <= 1'b0;
      sw_b_raw_i[NUM_MOTORS - 1] <= 1'b0;
      wait_frames(2);
      check_frame();
      check_column(COL_A_GREEN, grabbed[COL_A_GREEN], 16'h0001);
      check_column(COL_B_GREEN, grabbed[COL_B_GREEN], 16'h8000);
   endtask

   task automatic test_cfg_writes();
      logic [15:0] r;
      motor_idx_t  m;
      motor_cfg_t  d;
      for (int k = 0; k < 8; k++) begin
         take_bits(4, r);
         m = r[3:0];
         d.sw_a.invert = k[2];
         d.sw_a.color  = led_color_t'(k[1:0]);
         take_bits(1, r);
         d.sw_b.invert = r[0];
         take_bits(2, r);
         d.sw_b.color  = led_color_t'(r[1:0]);
         write_cfg(m, d);
      end
      // every combination of raw A and raw B levels
      for (int combo = 0; combo < 4; combo++) begin
         @(posedge display);
         sw_a_raw_i <= combo[1] ? '1 : '0;
         sw_b_raw_i <= combo[0] ? '1 : '0;
         wait_frames(2);
         check_frame();
      end
   endtask

   task automatic test_overheat();
      logic [15:0] r;
      take_bits(4, r);
      @(posedge display);
      overheat_i <= motor_vec_t'(1) << r[3:0];
      wait_frames(2);
      check_frame();
      check_column(COL_OVERHEAT, grabbed[COL_OVERHEAT], motor_vec_t'(1) << r[3:0]);
      @(posedge display);
      overheat_i <= '0;
   endtask

   task automatic test_fail_debounce();
      logic [15:0] r;
      motor_vec_t  bit_v;
      take_bits(4, r);
      bit_v = motor_vec_t'(1) << r[3:0];
      // sync to the latch of the column just before the fail column
      do begin
         @(posedge latch_o);
      end while (csel_o != column_idx_t'(COL_FAIL - 1));
      // short glitch whose last cycle is the load of the fail column
      // three ticks after that latch
      repeat (3 * SCAN_DIVIDER - FAIL_PULSE) @(posedge display);
      fail_i <= bit_v;
      repeat (FAIL_PULSE) @(posedge display);
      fail_i <= '0;
      // fail column of the next frame was loaded at the glitch end
      wait_frames(1);
      check_frame();
      @(posedge display);
      fail_i     <= bit_v;
      fail_model = bit_v;
      wait_frames(2);
      check_frame();
      @(posedge display);
      fail_i     <= '0;
      fail_model = '0;
      wait_frames(2);
      check_frame();
   endtask

   task automatic test_blink();
      int   low_run;
      int   p;
      logic want;
      // sync to a pulse that follows the long gap, i.e. a burst start
      low_run = 0;
      forever begin
         @(negedge display);
         if (!blink_o) begin
            low_run++;
         end else if (low_run > BLINK_OFF_CYCLES) begin
            break;
         end else begin
            low_run = 0;
         end
      end
      for (int i = 0; i < 5 * BLINK_PERIOD; i++) begin
         if (i > 0) begin
            @(negedge display);
         end
         p    = i % BLINK_PERIOD;
         want = (p / BLINK_SLOT < BLINK_PULSES) && (p % BLINK_SLOT < BLINK_ON_CYCLES);
         check_blink("blink_o", blink_o, want);
      end
   endtask

   initial begin
      cfg_we_i    <= 1'b0;
      cfg_motor_i <= '0;
      cfg_data_i  <= '0;
      sw_a_raw_i  <= '1;
      sw_b_raw_i  <= '1;
      overheat_i  <= '0;
      fail_i      <= '0;
      rst_n_i     <= 1'b0;
      // configuration after reset, both switches plain green
      for (int m = 0; m < NUM_MOTORS; m++) begin
         cfg_model[m] = '{sw_a: '{1'b0, LED_GREEN}, sw_b: '{1'b0, LED_GREEN}};
      end
      test_reset_and_order();
      test_default_mapping();
      test_cfg_writes();
      test_overheat();
      test_fail_debounce();
      test_blink();
      $display("errors: %0d value mismatches, %0d other failures", val_err, other_err);
      if (val_err == 0 && other_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- hw/led_panel_top.sv
//--------------------------------------------------------------------------
// LED status panel driver
// scans motor switch, overheat and fail status of a 16 motor crate onto
// an external 6 x 16 LED matrix driver and drives the heartbeat LED
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module led_panel_top (
   input  logic                       display,
   input  logic                       rst_n_i,
   // configuration write port
   input  logic                       cfg_we_i,
   input  led_panel_pkg::motor_idx_t  cfg_motor_i,
   input  led_panel_pkg::motor_cfg_t  cfg_data_i,
   // motor status
   input  led_panel_pkg::motor_vec_t  sw_a_raw_i,
   input  led_panel_pkg::motor_vec_t  sw_b_raw_i,
   input  led_panel_pkg::motor_vec_t  overheat_i,
   input  led_panel_pkg::motor_vec_t  fail_i,
   // LED matrix driver
   output logic                       blank_o,
   output logic                       sclk_o,
   output logic                       data_o,
   output logic                       latch_o,
   output led_panel_pkg::column_idx_t csel_o,
   output logic                       blink_o
);

   import led_panel_pkg::*;

   logic       scan_tick;
   logic       load;
   logic       shift;
   led_frame_t frame;

   scan_timer u_scan_timer (
      .display     (display),
      .rst_n_i     (rst_n_i),
      .scan_tick_o (scan_tick),
      .blink_o     (blink_o)
   );

   led_frame_builder u_led_frame_builder (
      .display     (display),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_motor_i (cfg_motor_i),
      .cfg_data_i  (cfg_data_i),
      .sw_a_raw_i  (sw_a_raw_i),
      .sw_b_raw_i  (sw_b_raw_i),
      .overheat_i  (overheat_i),
      .fail_i      (fail_i),
      .frame_o     (frame)
   );

   // csel drives both the panel and the shifter column mux
   scan_fsm u_scan_fsm (
      .display     (display),
      .rst_n_i     (rst_n_i),
      .scan_tick_i (scan_tick),
      .load_o      (load),
      .shift_o     (shift),
      .blank_o     (blank_o),
      .sclk_o      (sclk_o),
      .latch_o     (latch_o),
      .csel_o      (csel_o)
   );

   column_shifter u_column_shifter (
      .display (display),
      .rst_n_i (rst_n_i),
      .frame_i (frame),
      .csel_i  (csel_o),
      .load_i  (load),
      .shift_i (shift),
      .data_o  (data_o)
   );

endmodule

//--- hw/column_shifter.sv
//--------------------------------------------------------------------------
// Column shifter
// captures the selected frame column and serializes it msb first
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module column_shifter (
   input  logic                       display,
   input  logic                       rst_n_i,
   input  led_panel_pkg::led_frame_t  frame_i,
   input  led_panel_pkg::column_idx_t csel_i,
   input  logic                       load_i,
   input  logic                       shift_i,
   output logic                       data_o
);

   import led_panel_pkg::*;

   motor_vec_t shreg_q;

   always_ff @(posedge display or negedge rst_n_i) begin
      if (!rst_n_i) begin
         shreg_q <= '0;
      end else if (load_i) begin
         // motor 16 row leaves first
         shreg_q <= frame_i[csel_i];
      end else if (shift_i) begin
         shreg_q <= {shreg_q[NUM_MOTORS-2:0], 1'b0};
      end
   end

   assign data_o = shreg_q[NUM_MOTORS-1];

   // a load colliding with a shift would drop a bit
   a_load_shift: assert property (
      @(posedge display) disable iff (!rst_n_i) !(load_i && shift_i)
   ) else $error("load and shift in the same cycle");

endmodule

//--- hw/scan_fsm.sv
//--------------------------------------------------------------------------
// Matrix scan sequencer
// per column: blank, 16 shift clock periods, latch, then release blank
// and move to the next column; advances only on the scan tick
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module scan_fsm (
   input  logic                       display,
   input  logic                       rst_n_i,
   input  logic                       scan_tick_i,
   output logic                       load_o,
   output logic                       shift_o,
   output logic                       blank_o,
   output logic                       sclk_o,
   output logic                       latch_o,
   output led_panel_pkg::column_idx_t csel_o
);

   import led_panel_pkg::*;

   scan_state_t            state_q;
   logic [BIT_PHASE_W-1:0] bit_q;
   logic [BIT_PHASE_W-1:0] bit_nxt;

   assign bit_nxt = bit_q + 1'b1;

   // shifter strobes, one cycle wide, on the tick closing the phase
   // load at the end of blank, shift at the end of each sclk high phase
   assign load_o  = scan_tick_i && (state_q == ST_BLANK);
   assign shift_o = scan_tick_i && (state_q == ST_SHIFT) && bit_q[0];

   //-----------------------------------------------------------------------
   // state and registered panel outputs
   //-----------------------------------------------------------------------

   // reset into ST_NEXT so the first tick opens column 0
   always_ff @(posedge display or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_NEXT;
         bit_q   <= '0;
         csel_o  <= '0;
         blank_o <= 1'b0;
         sclk_o  <= 1'b0;
         latch_o <= 1'b0;
      end else if (scan_tick_i) begin
         case (state_q)
            ST_NEXT: begin
               state_q <= ST_BLANK;
               blank_o <= 1'b1;
            end
            ST_BLANK: begin
               state_q <= ST_SHIFT;
               bit_q   <= '0;
            end
            ST_SHIFT: begin
               if (bit_q == BIT_PHASE_W'(SHIFT_TICKS - 1)) begin
                  state_q <= ST_LATCH;
                  sclk_o  <= 1'b0;
                  latch_o <= 1'b1;
               end else begin
                  // odd phases drive sclk high
                  bit_q  <= bit_nxt;
                  sclk_o <= bit_nxt[0];
               end
            end
            ST_LATCH: begin
               state_q <= ST_NEXT;
               latch_o <= 1'b0;
               blank_o <= 1'b0;
               // wrap after the last column
               if (csel_o == column_idx_t'(NUM_COLUMNS - 1)) begin
                  csel_o <= '0;
               end else begin
                  csel_o <= csel_o + 1'b1;
               end
            end
            default: begin
               state_q <= ST_NEXT;
            end
         endcase
      end
   end

   // LED driver expects data clocked only while the outputs are dark
   a_sclk_blank: assert property (
      @(posedge display) disable iff (!rst_n_i) sclk_o |-> blank_o
   ) else $error("sclk active with blank released");

   a_latch_sclk: assert property (
      @(posedge display) disable iff (!rst_n_i) !(latch_o && sclk_o)
   ) else $error("latch and sclk overlap");

   a_csel_range: assert property (
      @(posedge display) disable iff (!rst_n_i) csel_o < NUM_COLUMNS
   ) else $error("column select out of range");

endmodule

//--- hw/led_frame_builder.sv
//--------------------------------------------------------------------------
// LED frame builder
// keeps the per-motor switch configuration, debounces the fail inputs
// and maps switch, overheat and fail status onto the six frame columns
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module led_frame_builder (
   input  logic                      display,
   input  logic                      rst_n_i,
   input  logic                      cfg_we_i,
   input  led_panel_pkg::motor_idx_t cfg_motor_i,
   input  led_panel_pkg::motor_cfg_t cfg_data_i,
   input  led_panel_pkg::motor_vec_t sw_a_raw_i,
   input  led_panel_pkg::motor_vec_t sw_b_raw_i,
   input  led_panel_pkg::motor_vec_t overheat_i,
   input  led_panel_pkg::motor_vec_t fail_i,
   output led_panel_pkg::led_frame_t frame_o
);

   import led_panel_pkg::*;

   motor_cfg_t            cfg_q      [NUM_MOTORS];
   logic [DEBOUNCE_W-1:0] deb_cnt_q  [NUM_MOTORS];
   motor_vec_t            fail_deb_q;

   // raw switch is active low, invert flips the sense
   function automatic logic actuated(input switch_cfg_t cfg, input logic raw);
      return (~raw) ^ cfg.invert;
   endfunction

   function automatic logic lit_green(input switch_cfg_t cfg, input logic raw);
      return actuated(cfg, raw) && ((cfg.color == LED_GREEN) || (cfg.color == LED_BOTH));
   endfunction

   function automatic logic lit_red(input switch_cfg_t cfg, input logic raw);
      return actuated(cfg, raw) && ((cfg.color == LED_RED) || (cfg.color == LED_BOTH));
   endfunction

   //-----------------------------------------------------------------------
   // switch configuration
   //-----------------------------------------------------------------------

   // one motor per write strobe, visible in the frame next cycle
   always_ff @(posedge display or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int m = 0; m < NUM_MOTORS; m++) begin
            cfg_q[m] <= MOTOR_CFG_RESET;
         end
      end else if (cfg_we_i) begin
         cfg_q[cfg_motor_i] <= cfg_data_i;
      end
   end

   //-----------------------------------------------------------------------
   // fail debouncing
   //-----------------------------------------------------------------------

   // counter runs only while the input disagrees with the debounced bit,
   // any return to the old level restarts it
   always_ff @(posedge display or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int m = 0; m < NUM_MOTORS; m++) begin
            deb_cnt_q[m] <= '0;
         end
         fail_deb_q <= '0;
      end else begin
         for (int m = 0; m < NUM_MOTORS; m++) begin
            if (fail_i[m] == fail_deb_q[m]) begin
               deb_cnt_q[m] <= '0;
            end else if (deb_cnt_q[m] == DEBOUNCE_W'(FAIL_DEBOUNCE_CYCLES - 1)) begin
               // stable long enough, take the new level
               deb_cnt_q[m]  <= '0;
               fail_deb_q[m] <= fail_i[m];
            end else begin
               deb_cnt_q[m] <= deb_cnt_q[m] + 1'b1;
            end
         end
      end
   end

   //-----------------------------------------------------------------------
   // frame mapping
   //-----------------------------------------------------------------------

   always_comb begin
      for (int m = 0; m < NUM_MOTORS; m++) begin
         // extremity switch A
         frame_o[COL_A_GREEN][m] = lit_green(cfg_q[m].sw_a, sw_a_raw_i[m]);
         frame_o[COL_A_RED][m]   = lit_red(cfg_q[m].sw_a, sw_a_raw_i[m]);
         // extremity switch B
         frame_o[COL_B_GREEN][m] = lit_green(cfg_q[m].sw_b, sw_b_raw_i[m]);
         frame_o[COL_B_RED][m]   = lit_red(cfg_q[m].sw_b, sw_b_raw_i[m]);
      end
      // overheat goes straight to the panel
      frame_o[COL_OVERHEAT] = overheat_i;
      frame_o[COL_FAIL]     = fail_deb_q;
   end

endmodule

//--- hw/scan_timer.sv
//--------------------------------------------------------------------------
// Scan timer
// divides the display clock down to the matrix scan tick and generates
// the front-panel heartbeat: a burst of short pulses, then a quiet gap
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module scan_timer (
   input  logic display,
   input  logic rst_n_i,
   output logic scan_tick_o,
   output logic blink_o
);

   import led_panel_pkg::*;

   logic [SCAN_DIV_W-1:0]    div_q;
   logic [BLINK_SLOT_W-1:0]  slot_q;
   logic [BLINK_PULSE_W-1:0] pulse_q;
   logic                     slot_end;

   //-----------------------------------------------------------------------
   // scan tick
   //-----------------------------------------------------------------------

   // free running divider, tick on the last count
   always_ff @(posedge display or negedge rst_n_i) begin
      if (!rst_n_i) begin
         div_q       <= '0;
         scan_tick_o <= 1'b0;
      end else begin
         div_q       <= div_q + 1'b1;
         scan_tick_o <= (div_q == SCAN_DIV_W'(SCAN_DIVIDER - 1));
      end
   end

   //-----------------------------------------------------------------------
   // heartbeat
   //-----------------------------------------------------------------------

   // one slot is an on/off pair, the gap is just one more slot
   // with the LED kept dark
   assign slot_end = (slot_q == BLINK_SLOT_W'(BLINK_ON_CYCLES + BLINK_OFF_CYCLES - 1));

   always_ff @(posedge display or negedge rst_n_i) begin
      if (!rst_n_i) begin
         slot_q  <= '0;
         pulse_q <= '0;
         blink_o <= 1'b0;
      end else begin
         if (slot_end) begin
            slot_q <= '0;
            // pulse count BLINK_PULSES marks the gap slot
            if (pulse_q == BLINK_PULSE_W'(BLINK_PULSES)) begin
               pulse_q <= '0;
            end else begin
               pulse_q <= pulse_q + 1'b1;
            end
         end else begin
            slot_q <= slot_q + 1'b1;
         end
         // lit in the first cycles of a slot, never in the gap
         blink_o <= (pulse_q != BLINK_PULSE_W'(BLINK_PULSES)) &&
                    (slot_q < BLINK_SLOT_W'(BLINK_ON_CYCLES));
      end
   end

   // the FSM relies on single cycle ticks
   a_tick_single: assert property (
      @(posedge display) disable iff (!rst_n_i)
      scan_tick_o |=> !scan_tick_o
   ) else $error("scan tick held for more than one cycle");

endmodule

//--- hw/led_panel_pkg.sv
//--------------------------------------------------------------------------
// LED status panel, shared definitions
// geometry of the 6 x 16 LED matrix, scan and blink timing, switch
// configuration records and the scan state encoding
//--------------------------------------------------------------------------

package led_panel_pkg;

   // panel geometry, one row per motor
   localparam int NUM_MOTORS  = 16;
   localparam int NUM_COLUMNS = 6;

   // timing, all in display clock cycles
   localparam int SCAN_DIVIDER         = 4;
   localparam int BLINK_ON_CYCLES      = 2;
   localparam int BLINK_OFF_CYCLES     = 3;
   localparam int BLINK_PULSES         = 3;
   localparam int FAIL_DEBOUNCE_CYCLES = 16;

   // derived counter sizes
   localparam int SHIFT_TICKS   = 2 * NUM_MOTORS;
   localparam int BIT_PHASE_W   = $clog2(SHIFT_TICKS);
   localparam int SCAN_DIV_W    = $clog2(SCAN_DIVIDER);
   localparam int BLINK_SLOT_W  = $clog2(BLINK_ON_CYCLES + BLINK_OFF_CYCLES);
   localparam int BLINK_PULSE_W = $clog2(BLINK_PULSES + 1);
   localparam int DEBOUNCE_W    = $clog2(FAIL_DEBOUNCE_CYCLES);

   // column assignment inside one frame
   localparam int COL_A_GREEN  = 0;
   localparam int COL_A_RED    = 1;
   localparam int COL_B_GREEN  = 2;
   localparam int COL_B_RED    = 3;
   localparam int COL_OVERHEAT = 4;
   localparam int COL_FAIL     = 5;

   typedef logic [NUM_MOTORS-1:0] motor_vec_t;
   typedef logic [3:0]            motor_idx_t;
   typedef logic [2:0]            column_idx_t;

   typedef enum logic [1:0] {LED_NONE, LED_GREEN, LED_RED, LED_BOTH} led_color_t;

   typedef struct packed {
      logic       invert;
      led_color_t color;
   } switch_cfg_t;

   // switch A sits in the upper half
   typedef struct packed {
      switch_cfg_t sw_a;
      switch_cfg_t sw_b;
   } motor_cfg_t;

   typedef motor_vec_t [NUM_COLUMNS-1:0] led_frame_t;

   typedef enum logic [1:0] {ST_BLANK, ST_SHIFT, ST_LATCH, ST_NEXT} scan_state_t;

   localparam motor_cfg_t MOTOR_CFG_RESET = '{
      sw_a: '{invert: 1'b0, color: LED_GREEN},
      sw_b: '{invert: 1'b0, color: LED_GREEN}
   };

endpackage
